// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FLIST     ?= cpu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing
PASS_TEXT ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

// File: common.sv
package common;

  // comparison commands leave 0 or 1 in bit 0
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_GE,
    ALU_GEU,
    ALU_PASS2
  } alu_cmd;

  typedef enum logic [2:0] {
    MEM_NONE,
    MEM_LB,
    MEM_LH,
    MEM_LW,
    MEM_SB,
    MEM_SH,
    MEM_SW
  } mem_access_type;

  // store width codes on write_wstrb
  localparam logic [1:0] WSTRB_BYTE = 2'd0;
  localparam logic [1:0] WSTRB_HALF = 2'd1;
  localparam logic [1:0] WSTRB_WORD = 2'd2;

  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_LOAD,
    WB_LINK
  } wb_src;

  typedef enum logic [1:0] {
    PC_NEXT,
    PC_BRANCH,
    PC_JAL,
    PC_JALR
  } pc_src;

endpackage

// File: cpu.f
riscv_instr.sv
common.sv
decoder.sv
execute.sv
memory_access.sv
cpu.sv
cpu_tb.sv

// File: cpu.sv
module cpu (
  input  logic        clock,
  input  logic        reset,
  // instruction memory
  output logic [31:0] pc,
  input  logic [31:0] instruction,
  // data memory
  output logic [31:0] address,
  input  logic [31:0] read_data,
  output logic        read_enable,
  output logic [31:0] write_data,
  output logic        write_enable,
  output logic [1:0]  write_wstrb,
  // debug view
  output logic        debug_ebreak,
  output logic [31:0] debug_reg [0:31]
);

  logic [31:0] reg_pc;
  logic [31:0] regfile [0:31];

  riscv_instr::instr_word instr;
  logic [4:0]  rd;
  logic [31:0] rs1_value;
  logic [31:0] rs2_value;

  common::alu_cmd         alu_ops;
  common::mem_access_type access_type;
  common::wb_src          wb_sel;
  common::pc_src          pc_sel;

  logic [31:0] op1;
  logic [31:0] op2;
  logic [31:0] alu_out;
  logic [31:0] target_base;
  logic [31:0] wb_mask;
  logic [31:0] pc_plus4;
  logic [31:0] wb_value;

  assign instr     = instruction;
  assign rd        = instr.r_fmt.rd;
  assign rs1_value = regfile[instr.r_fmt.rs1];
  assign rs2_value = regfile[instr.r_fmt.rs2];
  assign pc_plus4  = reg_pc + 32'd4;

  decoder decoder (
    .instruction    (instr),
    .pc             (reg_pc),
    .rs1_value      (rs1_value),
    .rs2_value      (rs2_value),
    .alu_result_bit (alu_out[0]),
    .alu_ops        (alu_ops),
    .access_type    (access_type),
    .op1            (op1),
    .op2            (op2),
    .wb_sel         (wb_sel),
    .pc_sel         (pc_sel),
    .target_base    (target_base)
  );

  execute execute (
    .op1     (op1),
    .op2     (op2),
    .alu_ops (alu_ops),
    .alu_out (alu_out)
  );

  memory_access memory_access (
    .reset        (reset),
    .access_type  (access_type),
    .read_enable  (read_enable),
    .write_enable (write_enable),
    .write_wstrb  (write_wstrb),
    .wb_mask      (wb_mask)
  );

  assign pc         = reg_pc;
  assign address    = alu_out;
  assign write_data = rs2_value;

  assign debug_ebreak = instruction == riscv_instr::EBREAK;
  assign debug_reg    = regfile;

  // loaded data already sits in the low bits
  always_comb begin
    case (wb_sel)
      common::WB_LOAD: wb_value = read_data & wb_mask;
      common::WB_LINK: wb_value = pc_plus4;
      default:         wb_value = alu_out;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      reg_pc <= 32'd0;
    end else if (pc_sel == common::PC_NEXT) begin
      reg_pc <= pc_plus4;
    end else begin
      reg_pc <= target_base;
    end
  end

  // x0 is never written, so it stays zero from reset
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regfile[i] <= 32'd0;
      end
    end else if (wb_sel != common::WB_NONE && rd != 5'd0) begin
      regfile[rd] <= wb_value;
    end
  end

endmodule

// File: cpu_tb.sv
module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] NOP = 32'h0000_0013;

  logic        clock;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] instruction;
  logic [31:0] address;
  logic [31:0] read_data;
  logic        read_enable;
  logic [31:0] write_data;
  logic        write_enable;
  logic [1:0]  write_wstrb;
  logic        debug_ebreak;
  logic [31:0] debug_reg [0:31];

  // memories and per-instruction expectations, indexed by word address
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] next_pc [0:255];
  bit          load_at [0:255];
  bit          store_at [0:255];
  logic [31:0] store_addr [0:255];
  logic [31:0] store_data [0:255];
  logic [1:0]  store_width [0:255];
  logic [31:0] expected [0:31];
  bit          checked [0:31];
  logic [7:0]  idx;
  logic [31:0] pc_expected;
  logic [31:0] boot_word;
  bit          stepped;
  int          n;
  int          limit;
  int          cycles = 0;

  cpu DUT (
    .clock, .reset, .pc, .instruction, .address, .read_data, .read_enable,
    .write_data, .write_enable, .write_wstrb, .debug_ebreak, .debug_reg
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    abort_run($sformatf("ERROR %s = %h, expected %h", name, got, want));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // instruction encoders, straight from the RV32I formats
  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], riscv_instr::OP_STORE};
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_instr::OP_BRANCH};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_instr::OP_JAL};
  endfunction

  function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                      input logic [31:0] y);
    case (f3)
      riscv_instr::F3_BEQ:  return x == y;
      riscv_instr::F3_BNE:  return x != y;
      riscv_instr::F3_BLT:  return $signed(x) < $signed(y);
      riscv_instr::F3_BGE:  return $signed(x) >= $signed(y);
      riscv_instr::F3_BLTU: return x < y;
      default:              return x >= y;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[n] = word;
    n = n + 1;
  endtask

  task automatic emit_checked(input logic [4:0] rd, input logic [31:0] word,
                              input logic [31:0] value);
    emit(word);
    expected[rd] = value;
    checked[rd] = 1'b1;
  endtask

  task automatic expect_load(input logic [4:0] rd, input logic [31:0] word,
                             input logic [31:0] value);
    load_at[n] = 1'b1;
    emit_checked(rd, word, value);
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    // addi sign-extends, so round the upper part
    upper = value + 32'h800;
    emit(u_word(upper[31:12], rd, riscv_instr::OP_LUI));
    emit_checked(rd, i_word(value[11:0], rd, riscv_instr::F3_ADD, rd, riscv_instr::OP_IMM),
                 value);
  endtask

  // register forms always read x1 and x2
  task automatic alu_reg(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                         input logic [31:0] value);
    emit_checked(rd, {f7, 5'd2, 5'd1, f3, rd, riscv_instr::OP_REG}, value);
  endtask

  task automatic alu_imm(input logic [11:0] imm, input logic [2:0] f3, input logic [4:0] rd,
                         input logic [31:0] value);
    emit_checked(rd, i_word(imm, 5'd1, f3, rd, riscv_instr::OP_IMM), value);
  endtask

  task automatic expect_store(input logic [31:0] word, input logic [31:0] value,
                              input logic [31:0] addr, input logic [1:0] width);
    store_at[n] = 1'b1;
    store_addr[n] = addr;
    store_data[n] = value;
    store_width[n] = width;
    emit(word);
  endtask

  // taken target skips the nop that follows
  task automatic add_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] here;
    here = 32'(4 * n);
    emit(b_word(13'd8, rs2, rs1, f3));
    next_pc[n - 1] = branch_taken(f3, expected[rs1], expected[rs2]) ? here + 32'd8
                                                                    : here + 32'd4;
    emit(NOP);
  endtask

  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rnd;
    logic [11:0] imm;
    logic [31:0] ie;
    logic [4:0]  sh;
    logic [31:0] here;
    logic [2:0]  conds [6];
    conds = '{riscv_instr::F3_BEQ, riscv_instr::F3_BNE, riscv_instr::F3_BLT,
              riscv_instr::F3_BGE, riscv_instr::F3_BLTU, riscv_instr::F3_BGEU};
    // unused words are addi x0 with the word index as immediate
    for (int i = 0; i < 256; i++) begin
      imem[i] = i_word(12'(i), 5'd0, riscv_instr::F3_ADD, 5'd0, riscv_instr::OP_IMM);
      dmem[i] = 32'h9e37_79b9 * 32'(i + 1);
      next_pc[i] = 32'(4 * i + 4);
    end
    n = 0;
    a = xorshift(32'hf1a7_7ca7);
    b = xorshift(a);
    rnd = xorshift(b);
    imm = rnd[11:0];
    sh = rnd[16:12];
    ie = {{20{imm[11]}}, imm};
    // a load into x0 is dropped as well
    expect_load(5'd0, i_word(12'd0, 5'd0, riscv_instr::F3_LW, 5'd0, riscv_instr::OP_LOAD), 0);
    load_const(5'd1, a);
    load_const(5'd2, b);
    alu_reg(7'd0, riscv_instr::F3_ADD, 5'd3, a + b);
    alu_reg(riscv_instr::F7_ALT, riscv_instr::F3_ADD, 5'd4, a - b);
    alu_reg(7'd0, riscv_instr::F3_AND, 5'd5, a & b);
    alu_reg(7'd0, riscv_instr::F3_OR, 5'd6, a | b);
    alu_reg(7'd0, riscv_instr::F3_XOR, 5'd7, a ^ b);
    alu_reg(7'd0, riscv_instr::F3_SLL, 5'd8, a << b[4:0]);
    alu_reg(7'd0, riscv_instr::F3_SR, 5'd9, a >> b[4:0]);
    alu_reg(riscv_instr::F7_ALT, riscv_instr::F3_SR, 5'd10, 32'($signed(a) >>> b[4:0]));
    alu_reg(7'd0, riscv_instr::F3_SLT, 5'd11, {31'd0, $signed(a) < $signed(b)});
    alu_reg(7'd0, riscv_instr::F3_SLTU, 5'd12, {31'd0, a < b});
    alu_imm(imm, riscv_instr::F3_ADD, 5'd13, a + ie);
    alu_imm(imm, riscv_instr::F3_AND, 5'd14, a & ie);
    alu_imm(imm, riscv_instr::F3_OR, 5'd15, a | ie);
    alu_imm(imm, riscv_instr::F3_XOR, 5'd16, a ^ ie);
    alu_imm(imm, riscv_instr::F3_SLT, 5'd17, {31'd0, $signed(a) < $signed(ie)});
    alu_imm(imm, riscv_instr::F3_SLTU, 5'd18, {31'd0, a < ie});
    alu_imm({7'd0, sh}, riscv_instr::F3_SLL, 5'd19, a << sh);
    alu_imm({7'd0, sh}, riscv_instr::F3_SR, 5'd20, a >> sh);
    alu_imm({riscv_instr::F7_ALT, sh}, riscv_instr::F3_SR, 5'd21, 32'($signed(a) >>> sh));
    here = 32'(4 * n);
    emit_checked(5'd22, u_word(b[31:12], 5'd22, riscv_instr::OP_AUIPC), here + {b[31:12], 12'h0});
    // a write to x0 must be lost
    emit_checked(5'd0, i_word(12'h123, 5'd1, riscv_instr::F3_ADD, 5'd0, riscv_instr::OP_IMM), 0);
    emit_checked(5'd23, i_word(12'h100, 5'd0, riscv_instr::F3_ADD, 5'd23, riscv_instr::OP_IMM),
                 32'h100);
    expect_store(s_word(12'd0, 5'd1, 5'd23, riscv_instr::F3_SW), a, 32'h100, common::WSTRB_WORD);
    expect_store(s_word(12'd4, 5'd2, 5'd23, riscv_instr::F3_SH), b, 32'h104, common::WSTRB_HALF);
    expect_store(s_word(12'd9, 5'd1, 5'd23, riscv_instr::F3_SB), a, 32'h109, common::WSTRB_BYTE);
    expect_load(5'd24, i_word(12'd0, 5'd23, riscv_instr::F3_LW, 5'd24, riscv_instr::OP_LOAD), a);
    expect_load(5'd25, i_word(12'd4, 5'd23, riscv_instr::F3_LHU, 5'd25, riscv_instr::OP_LOAD),
                {16'd0, b[15:0]});
    expect_load(5'd26, i_word(12'd9, 5'd23, riscv_instr::F3_LBU, 5'd26, riscv_instr::OP_LOAD),
                {24'd0, a[7:0]});
    // -1 and 1 give both outcomes for every branch
    emit_checked(5'd27, i_word(12'hfff, 5'd0, riscv_instr::F3_ADD, 5'd27, riscv_instr::OP_IMM),
                 32'hffff_ffff);
    emit_checked(5'd28, i_word(12'h001, 5'd0, riscv_instr::F3_ADD, 5'd28, riscv_instr::OP_IMM),
                 32'd1);
    foreach (conds[k]) begin
      add_branch(conds[k], 5'd28, 5'd27);
      add_branch(conds[k], 5'd27, 5'd28);
      add_branch(conds[k], 5'd28, 5'd28);
    end
    here = 32'(4 * n);
    emit_checked(5'd30, j_word(21'd12, 5'd30), here + 32'd4);
    next_pc[n - 1] = here + 32'd12;
    emit(NOP);
    emit(NOP);
    // jalr base plus 3 is odd, bit 0 gets cleared
    here = 32'(4 * n + 4);
    emit_checked(5'd31, i_word(12'(here + 32'd10), 5'd0, riscv_instr::F3_ADD, 5'd31,
                               riscv_instr::OP_IMM), here + 32'd10);
    emit_checked(5'd29, i_word(12'd3, 5'd31, 3'b000, 5'd29, riscv_instr::OP_JALR), here + 32'd4);
    next_pc[n - 1] = here + 32'd12;
    emit(NOP);
    emit(NOP);
    emit(riscv_instr::EBREAK);
    limit = 2 * n + 50;
  endtask

  assign idx = pc[9:2];
  assign instruction = imem[idx];
  // byte and halfword land in the low bits
  assign read_data = dmem[address[9:2]] >> {address[1:0], 3'b000};

  always @(posedge clock) begin
    if (write_enable) begin
      case (write_wstrb)
        common::WSTRB_BYTE: dmem[address[9:2]][{address[1:0], 3'b000} +: 8] <= write_data[7:0];
        common::WSTRB_HALF: dmem[address[9:2]][{address[1:0], 3'b000} +: 16] <= write_data[15:0];
        default:            dmem[address[9:2]] <= write_data;
      endcase
    end
  end

  always @(posedge clock) begin
    stepped     <= !reset;
    pc_expected <= next_pc[idx];
    cycles      <= cycles + 1;
    if (cycles > limit) begin
      abort_run($sformatf("timeout, ebreak not reached within %0d cycles", limit));
    end
  end

  assert property (@(posedge clock) reset |-> !read_enable && !write_enable && pc == 32'd0)
    else abort_run("a memory enable or a nonzero pc was seen during reset");

  assert property (@(posedge clock) disable iff (reset) stepped |-> pc == pc_expected)
    else report_mismatch("pc", $sampled(pc), $sampled(pc_expected));

  // enables follow the instruction kind once out of reset
  assert property (@(posedge clock) !reset |-> read_enable == load_at[idx])
    else report_mismatch("read_enable", 32'($sampled(read_enable)),
                         32'($sampled(load_at[idx])));

  assert property (@(posedge clock) !reset |-> write_enable == store_at[idx])
    else report_mismatch("write_enable", 32'($sampled(write_enable)),
                         32'($sampled(store_at[idx])));

  assert property (@(posedge clock) disable iff (reset)
      store_at[idx] |-> write_wstrb == store_width[idx])
    else report_mismatch("write_wstrb", 32'($sampled(write_wstrb)),
                         32'($sampled(store_width[idx])));

  assert property (@(posedge clock) disable iff (reset)
      store_at[idx] |-> address == store_addr[idx])
    else report_mismatch("address", $sampled(address), $sampled(store_addr[idx]));

  assert property (@(posedge clock) disable iff (reset)
      store_at[idx] |-> write_data == store_data[idx])
    else report_mismatch("write_data", $sampled(write_data), $sampled(store_data[idx]));

  for (genvar r = 0; r < 32; r++) begin : reg_checks
    assert property (@(posedge clock) disable iff (reset)
        debug_ebreak && checked[r] |-> debug_reg[r] == expected[r])
      else report_mismatch($sformatf("debug_reg[%0d]", r), $sampled(debug_reg[r]), expected[r]);
  end

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    build_program();
    // pc 0 holds a store for the first half of reset, then the program's load
    boot_word = imem[0];
    imem[0] = s_word(12'd0, 5'd0, 5'd0, riscv_instr::F3_SW);
    repeat (4) @(posedge clock);
    imem[0] = boot_word;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    while (!debug_ebreak) @(negedge clock);
    // register checks run on the edge that closes the ebreak cycle
    @(negedge clock);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: decoder.sv
module decoder (
  input  riscv_instr::instr_word     instruction,
  input  logic [31:0]                pc,
  input  logic [31:0]                rs1_value,
  input  logic [31:0]                rs2_value,
  input  logic                       alu_result_bit,
  output common::alu_cmd             alu_ops,
  output common::mem_access_type     access_type,
  output logic [31:0]                op1,
  output logic [31:0]                op2,
  output common::wb_src              wb_sel,
  output common::pc_src              pc_sel,
  output logic [31:0]                target_base
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        alt;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] jalr_sum;

  // register and immediate forms share funct3; sub only exists as register op
  function automatic common::alu_cmd arith_cmd(input logic [2:0] f3, input logic sub_sra,
                                               input logic is_reg);
    common::alu_cmd cmd;
    case (f3)
      riscv_instr::F3_ADD:  cmd = (sub_sra && is_reg) ? common::ALU_SUB : common::ALU_ADD;
      riscv_instr::F3_SLL:  cmd = common::ALU_SLL;
      riscv_instr::F3_SLT:  cmd = common::ALU_SLT;
      riscv_instr::F3_SLTU: cmd = common::ALU_SLTU;
      riscv_instr::F3_XOR:  cmd = common::ALU_XOR;
      riscv_instr::F3_SR:   cmd = sub_sra ? common::ALU_SRA : common::ALU_SRL;
      riscv_instr::F3_OR:   cmd = common::ALU_OR;
      default:              cmd = common::ALU_AND;
    endcase
    return cmd;
  endfunction

  assign opcode = instruction.r_fmt.opcode;
  assign funct3 = instruction.r_fmt.funct3;
  assign alt    = instruction.r_fmt.funct7 == riscv_instr::F7_ALT;

  // immediates, one per format
  assign imm_i = {{20{instruction.i_fmt.imm[11]}}, instruction.i_fmt.imm};
  assign imm_s = {{20{instruction.s_fmt.imm_hi[6]}}, instruction.s_fmt.imm_hi,
                  instruction.s_fmt.imm_lo};
  assign imm_b = {{20{instruction.b_fmt.imm_12}}, instruction.b_fmt.imm_11,
                  instruction.b_fmt.imm_10_5, instruction.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {instruction.u_fmt.imm, 12'h000};
  assign imm_j = {{12{instruction.j_fmt.imm_20}}, instruction.j_fmt.imm_19_12,
                  instruction.j_fmt.imm_11, instruction.j_fmt.imm_10_1, 1'b0};

  assign jalr_sum = rs1_value + imm_i;

  always_comb begin
    alu_ops     = common::ALU_ADD;
    access_type = common::MEM_NONE;
    op1         = rs1_value;
    op2         = imm_i;
    wb_sel      = common::WB_NONE;
    case (opcode)
      riscv_instr::OP_REG: begin
        alu_ops = arith_cmd(funct3, alt, 1'b1);
        op2     = rs2_value;
        wb_sel  = common::WB_ALU;
      end
      riscv_instr::OP_IMM: begin
        // srai carries the alt bit in imm[10]
        alu_ops = arith_cmd(funct3, alt, 1'b0);
        wb_sel  = common::WB_ALU;
      end
      riscv_instr::OP_LUI: begin
        alu_ops = common::ALU_PASS2;
        op2     = imm_u;
        wb_sel  = common::WB_ALU;
      end
      riscv_instr::OP_AUIPC: begin
        op1    = pc;
        op2    = imm_u;
        wb_sel = common::WB_ALU;
      end
      riscv_instr::OP_LOAD: begin
        wb_sel = common::WB_LOAD;
        case (funct3)
          riscv_instr::F3_LW:  access_type = common::MEM_LW;
          riscv_instr::F3_LHU: access_type = common::MEM_LH;
          riscv_instr::F3_LBU: access_type = common::MEM_LB;
          default:             wb_sel = common::WB_NONE;
        endcase
      end
      riscv_instr::OP_STORE: begin
        op2 = imm_s;
        case (funct3)
          riscv_instr::F3_SW: access_type = common::MEM_SW;
          riscv_instr::F3_SH: access_type = common::MEM_SH;
          riscv_instr::F3_SB: access_type = common::MEM_SB;
          default:            access_type = common::MEM_NONE;
        endcase
      end
      riscv_instr::OP_BRANCH: begin
        op2 = rs2_value;
        case (funct3)
          riscv_instr::F3_BEQ:  alu_ops = common::ALU_EQ;
          riscv_instr::F3_BNE:  alu_ops = common::ALU_NE;
          riscv_instr::F3_BLT:  alu_ops = common::ALU_SLT;
          riscv_instr::F3_BGE:  alu_ops = common::ALU_GE;
          riscv_instr::F3_BLTU: alu_ops = common::ALU_SLTU;
          default:              alu_ops = common::ALU_GEU;
        endcase
      end
      riscv_instr::OP_JAL, riscv_instr::OP_JALR: begin
        wb_sel = common::WB_LINK;
      end
      // ebreak only raises the debug flag in the top level
      riscv_instr::OP_SYSTEM: wb_sel = common::WB_NONE;
      default: wb_sel = common::WB_NONE;
    endcase
  end

  // kept apart from the operand logic since it depends on the alu result
  always_comb begin
    case (opcode)
      riscv_instr::OP_BRANCH: pc_sel = alu_result_bit ? common::PC_BRANCH : common::PC_NEXT;
      riscv_instr::OP_JAL:    pc_sel = common::PC_JAL;
      riscv_instr::OP_JALR:   pc_sel = common::PC_JALR;
      default:                pc_sel = common::PC_NEXT;
    endcase
  end

  always_comb begin
    case (opcode)
      riscv_instr::OP_JAL:  target_base = pc + imm_j;
      riscv_instr::OP_JALR: target_base = {jalr_sum[31:1], 1'b0};
      default:              target_base = pc + imm_b;
    endcase
  end

endmodule

// File: execute.sv
module execute (
  input  logic [31:0]    op1,
  input  logic [31:0]    op2,
  input  common::alu_cmd alu_ops,
  output logic [31:0]    alu_out
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  // only the low five bits count for shifts
  assign shamt = op2[4:0];

  assign lt_signed   = $signed(op1) < $signed(op2);
  assign lt_unsigned = op1 < op2;
  assign equal       = op1 == op2;

  always_comb begin
    case (alu_ops)
      common::ALU_ADD: alu_out = op1 + op2;
      common::ALU_SUB: alu_out = op1 - op2;
      common::ALU_AND: alu_out = op1 & op2;
      common::ALU_OR:  alu_out = op1 | op2;
      common::ALU_XOR: alu_out = op1 ^ op2;
      common::ALU_SLL: alu_out = op1 << shamt;
      common::ALU_SRL: alu_out = op1 >> shamt;
      common::ALU_SRA: alu_out = $unsigned($signed(op1) >>> shamt);

      // compare results in bit 0
      common::ALU_SLT:  alu_out = {31'd0, lt_signed};
      common::ALU_SLTU: alu_out = {31'd0, lt_unsigned};
      common::ALU_EQ:   alu_out = {31'd0, equal};
      common::ALU_NE:   alu_out = {31'd0, !equal};
      common::ALU_GE:   alu_out = {31'd0, !lt_signed};
      common::ALU_GEU:  alu_out = {31'd0, !lt_unsigned};

      // lui
      common::ALU_PASS2: alu_out = op2;
      default:           alu_out = op1 + op2;
    endcase
  end

endmodule

// File: memory_access.sv
module memory_access (
  input  logic                   reset,
  input  common::mem_access_type access_type,
  output logic                   read_enable,
  output logic                   write_enable,
  output logic [1:0]             write_wstrb,
  output logic [31:0]            wb_mask
);

  logic is_load;
  logic is_store;

  always_comb begin
    is_load     = 1'b0;
    is_store    = 1'b0;
    write_wstrb = common::WSTRB_WORD;
    wb_mask     = 32'hffff_ffff;
    case (access_type)
      common::MEM_LB: begin
        is_load     = 1'b1;
        write_wstrb = common::WSTRB_BYTE;
        wb_mask     = 32'h0000_00ff;
      end
      common::MEM_LH: begin
        is_load     = 1'b1;
        write_wstrb = common::WSTRB_HALF;
        wb_mask     = 32'h0000_ffff;
      end
      common::MEM_LW: is_load = 1'b1;
      common::MEM_SB: begin
        is_store    = 1'b1;
        write_wstrb = common::WSTRB_BYTE;
      end
      common::MEM_SH: begin
        is_store    = 1'b1;
        write_wstrb = common::WSTRB_HALF;
      end
      common::MEM_SW: is_store = 1'b1;
      default: ;
    endcase
  end

  // no memory traffic while in reset
  assign read_enable  = is_load && !reset;
  assign write_enable = is_store && !reset;

endmodule

// File: riscv_instr.sv
package riscv_instr;

  // major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // loads are zero-extended only
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  localparam logic [2:0] F3_SB = 3'b000;
  localparam logic [2:0] F3_SH = 3'b001;
  localparam logic [2:0] F3_SW = 3'b010;

  // alu functions, shared by register and immediate forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 of sub and sra
  localparam logic [6:0] F7_ALT = 7'b0100000;

  localparam logic [31:0] EBREAK = 32'h0010_0073;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type;

  typedef union packed {
    r_type r_fmt;
    i_type i_fmt;
    s_type s_fmt;
    b_type b_fmt;
    u_type u_fmt;
    j_type j_fmt;
  } instr_word;

endpackage
